//--- rtl/sprite_cfg.svh
// ======================================
// Sprite configuration
// Sizes shared by the sprite pixel path
// ======================================
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

`default_nettype none

// Eight hardware sprites, addressed by a three bit index
`define SPRITE_COUNT 8
`define SPRITE_BITS 3

// One sprite line is three data bytes wide
`define SHIFT_WIDTH 24

// Palette index width
`define COLOR_BITS 4

`default_nettype wire

`endif

//--- rtl/vicBusPkg.sv
// ======================================
// Bus-side types
// Fetched bytes and shifter load requests
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

package vicBusPkg;

	// One byte as it comes off the memory bus during a sprite fetch
	// Sprite selects which of the eight shifters the byte belongs to
	typedef struct packed {
		logic [`SPRITE_BITS-1:0] sprite;
		logic [7:0] data;
	} fetchByteT;

	// A byte on its way into a sprite shifter
	// LastByte flags the third byte of the line, after which the
	// sprite is ready to start at its X position
	typedef struct packed {
		logic [`SPRITE_BITS-1:0] sprite;
		logic [7:0] data;
		logic lastByte;
	} spriteLoadT;

endpackage

`default_nettype wire

//--- rtl/spritePkg.sv
// ======================================
// Sprite-side types
// Control, pixel codes, states and output
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

package spritePkg;

	// Per-sprite control as the register file would present it
	typedef struct packed {
		logic active;
		logic multicolor;
		logic xExpand;
		logic [8:0] xPos;
		logic [`COLOR_BITS-1:0] color;
	} spriteCtrlT;

	// Two bit pixel code out of the shifter
	// A high-resolution 1 bit is presented as PIX_SPRITE
	typedef enum logic [1:0] {
		PIX_CLEAR  = 2'b00,
		PIX_MC0    = 2'b01,
		PIX_SPRITE = 2'b10,
		PIX_MC1    = 2'b11
	} pixCodeE;

	// Shifter life cycle
	// IDLE collects bytes, ARMED waits for the X match, RUN shifts out
	typedef enum logic [1:0] {
		SHIFT_IDLE  = 2'b00,
		SHIFT_ARMED = 2'b01,
		SHIFT_RUN   = 2'b10
	} shiftStateE;

	// Resolved output pixel
	// Valid low means no sprite covers this pixel
	typedef struct packed {
		logic valid;
		logic [`SPRITE_BITS-1:0] sprite;
		logic [`COLOR_BITS-1:0] color;
	} pixelOutT;

endpackage

`default_nettype wire

//--- rtl/spriteFetch.sv
// ======================================
// Sprite fetch stage
// Buffers bus bytes, counts three per
// sprite and forwards them to the shifter
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

module spriteFetch (
	input  wire logic clk33,
	input  wire logic rst,
	input  wire logic busValid,
	input  wire vicBusPkg::fetchByteT busIn,
	input  wire spritePkg::spriteCtrlT [`SPRITE_COUNT-1:0] spriteCtrl,
	input  wire logic loadReady,
	output logic busReady,
	output logic loadValid,
	output vicBusPkg::spriteLoadT load
);

	// Index of the last byte in a sprite line
	localparam logic [1:0] LastIdx = 2'(`SHIFT_WIDTH / 8 - 1);

	// One entry holding register in front of the load link
	logic holdValid;
	vicBusPkg::spriteLoadT hold;

	// Byte position within the current line, one counter per sprite
	logic [1:0] byteCnt [`SPRITE_COUNT];

	logic busAccept;
	logic drain;
	logic byteActive;

	assign loadValid = holdValid;
	assign load = hold;

	// The holding register empties on the same clock that the shifter takes it
	assign drain = holdValid && loadReady;
	assign busReady = !holdValid || drain;
	assign busAccept = busValid && busReady;

	// Bytes for switched-off sprites are swallowed here
	assign byteActive = spriteCtrl[busIn.sprite].active;

	// ======================================
	// Holding register and byte counters
	// ======================================
	always_ff @(posedge clk33) begin
		if (rst) begin
			holdValid <= 1'b0;
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				byteCnt[i] <= 2'd0;
			end
		end else begin
			if (drain) begin
				holdValid <= 1'b0;
			end
			if (busAccept && byteActive) begin
				holdValid <= 1'b1;
				// Third byte wraps the counter so the next line starts clean
				if (byteCnt[busIn.sprite] == LastIdx) begin
					byteCnt[busIn.sprite] <= 2'd0;
				end else begin
					byteCnt[busIn.sprite] <= byteCnt[busIn.sprite] + 2'd1;
				end
			end
		end
	end

	// Payload follows the accept, no reset needed
	always_ff @(posedge clk33) begin
		if (busAccept && byteActive) begin
			hold.sprite <= busIn.sprite;
			hold.data <= busIn.data;
			hold.lastByte <= (byteCnt[busIn.sprite] == LastIdx);
		end
	end

	// A stalled load must not change under the shifter
	assert property (@(posedge clk33) disable iff (rst)
		loadValid && !loadReady |=> loadValid && $stable(load))
		else $error("spriteFetch: load changed while stalled");

endmodule

`default_nettype wire

//--- rtl/spritePixelShifter.sv
// ======================================
// Sprite pixel shifter
// Holds a 24 bit line per sprite and
// shifts pixel codes out from the X match
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

module spritePixelShifter (
	input  wire logic clk33,
	input  wire logic rst,
	input  wire logic pixelEn,
	input  wire logic [8:0] rasterX,
	input  wire spritePkg::spriteCtrlT [`SPRITE_COUNT-1:0] spriteCtrl,
	input  wire logic loadValid,
	input  wire vicBusPkg::spriteLoadT load,
	output logic loadReady,
	output spritePkg::pixCodeE [`SPRITE_COUNT-1:0] pixCode
);

	// Last run count for a normal and for an X-expanded sprite
	localparam logic [5:0] RunLast = 6'(`SHIFT_WIDTH - 1);
	localparam logic [5:0] RunLastX = 6'(2 * `SHIFT_WIDTH - 1);

	logic [`SHIFT_WIDTH-1:0] pixels [`SPRITE_COUNT];
	spritePkg::shiftStateE state [`SPRITE_COUNT];
	logic [5:0] runCnt [`SPRITE_COUNT];
	// Flips every pixel of an expanded sprite, shifting happens on the high half
	logic xTog [`SPRITE_COUNT];

	logic loadAccept;

	// A running sprite cannot take new data until its line is out
	assign loadReady = (state[load.sprite] != spritePkg::SHIFT_RUN);
	assign loadAccept = loadValid && loadReady;

	// ======================================
	// Line registers
	// ======================================
	always_ff @(posedge clk33) begin
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			if (loadAccept && load.sprite == `SPRITE_BITS'(i)) begin
				// New bytes enter at the low end, the first byte ends on top
				pixels[i] <= {pixels[i][`SHIFT_WIDTH-9:0], load.data};
			end else if (pixelEn && state[i] == spritePkg::SHIFT_RUN) begin
				// Shift once per pixel, or once per pixel pair in multicolor
				if (!spriteCtrl[i].xExpand || xTog[i]) begin
					if (!spriteCtrl[i].multicolor) begin
						pixels[i] <= {pixels[i][`SHIFT_WIDTH-2:0], 1'b0};
					end else if (spriteCtrl[i].xExpand ? runCnt[i][1] : runCnt[i][0]) begin
						pixels[i] <= {pixels[i][`SHIFT_WIDTH-3:0], 2'b00};
					end
				end
			end
		end
	end

	// ======================================
	// State, run counter and code output
	// ======================================
	always_ff @(posedge clk33) begin
		if (rst) begin
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				state[i] <= spritePkg::SHIFT_IDLE;
				runCnt[i] <= 6'd0;
				xTog[i] <= 1'b0;
				pixCode[i] <= spritePkg::PIX_CLEAR;
			end
		end else begin
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				// Third byte in arms the sprite
				if (loadAccept && load.sprite == `SPRITE_BITS'(i) && load.lastByte) begin
					state[i] <= spritePkg::SHIFT_ARMED;
				end
				if (pixelEn) begin
					if (state[i] == spritePkg::SHIFT_RUN) begin
						// Hi-res shows the top bit as PIX_SPRITE or PIX_CLEAR
						if (spriteCtrl[i].multicolor) begin
							pixCode[i] <= spritePkg::pixCodeE'(pixels[i][`SHIFT_WIDTH-1 -: 2]);
						end else begin
							pixCode[i] <= spritePkg::pixCodeE'({pixels[i][`SHIFT_WIDTH-1], 1'b0});
						end
						xTog[i] <= !xTog[i];
						runCnt[i] <= runCnt[i] + 6'd1;
						if (runCnt[i] == (spriteCtrl[i].xExpand ? RunLastX : RunLast)) begin
							state[i] <= spritePkg::SHIFT_IDLE;
						end
					end else begin
						pixCode[i] <= spritePkg::PIX_CLEAR;
						// Start on the X match, first code follows one pixel later
						if (state[i] == spritePkg::SHIFT_ARMED && rasterX == spriteCtrl[i].xPos) begin
							state[i] <= spritePkg::SHIFT_RUN;
							runCnt[i] <= 6'd0;
							xTog[i] <= 1'b0;
						end
					end
				end
			end
		end
	end

	// While a sprite runs its line only changes by shifting on pixel enables
	for (genvar g = 0; g < `SPRITE_COUNT; g++) begin : gRunChk
		assert property (@(posedge clk33) disable iff (rst)
			state[g] == spritePkg::SHIFT_RUN && !pixelEn |=> $stable(pixels[g]))
			else $error("spritePixelShifter: sprite %0d written while running", g);
	end

endmodule

`default_nettype wire

//--- rtl/spritePriorityMux.sv
// ======================================
// Sprite priority mux
// Maps codes to colours, lowest opaque
// sprite wins, one registered pixel out
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

module spritePriorityMux (
	input  wire logic clk33,
	input  wire logic rst,
	input  wire logic pixelEn,
	input  wire spritePkg::pixCodeE [`SPRITE_COUNT-1:0] pixCode,
	input  wire spritePkg::spriteCtrlT [`SPRITE_COUNT-1:0] spriteCtrl,
	input  wire logic [`COLOR_BITS-1:0] mcColor0,
	input  wire logic [`COLOR_BITS-1:0] mcColor1,
	output spritePkg::pixelOutT pixelOut
);

	spritePkg::pixelOutT nextPix;

	// ======================================
	// Priority resolve
	// ======================================
	always_comb begin
		nextPix.valid = 1'b0;
		nextPix.sprite = '0;
		nextPix.color = '0;
		// Walk from the top so the lowest opaque index is the last to write
		for (int i = `SPRITE_COUNT - 1; i >= 0; i--) begin
			if (pixCode[i] != spritePkg::PIX_CLEAR) begin
				nextPix.valid = 1'b1;
				nextPix.sprite = `SPRITE_BITS'(i);
				case (pixCode[i])
					spritePkg::PIX_MC0: nextPix.color = mcColor0;
					spritePkg::PIX_MC1: nextPix.color = mcColor1;
					default: nextPix.color = spriteCtrl[i].color;
				endcase
			end
		end
	end

	// Valid is control and gets cleared by reset
	always_ff @(posedge clk33) begin
		if (rst) begin
			pixelOut.valid <= 1'b0;
		end else if (pixelEn) begin
			pixelOut.valid <= nextPix.valid;
		end
	end

	// Index and colour only mean something while valid is high
	always_ff @(posedge clk33) begin
		if (pixelEn) begin
			pixelOut.sprite <= nextPix.sprite;
			pixelOut.color <= nextPix.color;
		end
	end

endmodule

`default_nettype wire

//--- rtl/spriteUnit.sv
// ======================================
// Sprite unit
// Fetch, shifter and priority mux
// ======================================
`include "sprite_cfg.svh"
`default_nettype none

module spriteUnit (
	input  wire logic clk33,
	input  wire logic rst,
	input  wire logic pixelEn,
	input  wire logic [8:0] rasterX,
	input  wire vicBusPkg::fetchByteT busIn,
	input  wire logic busValid,
	input  wire spritePkg::spriteCtrlT [`SPRITE_COUNT-1:0] spriteCtrl,
	input  wire logic [`COLOR_BITS-1:0] mcColor0,
	input  wire logic [`COLOR_BITS-1:0] mcColor1,
	output logic busReady,
	output spritePkg::pixelOutT pixelOut
);

	// Load link between fetch and shifter
	logic loadValid;
	logic loadReady;
	vicBusPkg::spriteLoadT load;

	// One code per sprite into the priority stage
	spritePkg::pixCodeE [`SPRITE_COUNT-1:0] pixCode;

	spriteFetch fetch (
		.clk33(clk33),
		.rst(rst),
		.busValid(busValid),
		.busIn(busIn),
		.spriteCtrl(spriteCtrl),
		.loadReady(loadReady),
		.busReady(busReady),
		.loadValid(loadValid),
		.load(load)
	);

	spritePixelShifter shifter (
		.clk33(clk33),
		.rst(rst),
		.pixelEn(pixelEn),
		.rasterX(rasterX),
		.spriteCtrl(spriteCtrl),
		.loadValid(loadValid),
		.load(load),
		.loadReady(loadReady),
		.pixCode(pixCode)
	);

	spritePriorityMux prioMux (
		.clk33(clk33),
		.rst(rst),
		.pixelEn(pixelEn),
		.pixCode(pixCode),
		.spriteCtrl(spriteCtrl),
		.mcColor0(mcColor0),
		.mcColor1(mcColor1),
		.pixelOut(pixelOut)
	);

endmodule

`default_nettype wire

//--- sim/spriteUnitTb.sv
// ========================================
// Sprite unit testbench
// Loads sprite lines over the bus and checks
// the pixel stream against a reference queue
// ========================================
`include "sprite_cfg.svh"
`default_nettype none

module spriteUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ReadyTimeout = 400;
	localparam int PixelTimeout = 16;

	logic clk33;
	logic rst;
	logic pixelEn = 1'b0;
	logic [1:0] pixDiv = 2'd0;
	logic [8:0] rasterX;
	vicBusPkg::fetchByteT busIn;
	logic busValid;
	spritePkg::spriteCtrlT [`SPRITE_COUNT-1:0] spriteCtrl;
	logic [`COLOR_BITS-1:0] mcColor0;
	logic [`COLOR_BITS-1:0] mcColor1;
	logic busReady;
	spritePkg::pixelOutT pixelOut;

	// Reference model holds one line pattern per sprite and the set of sprites now running
	logic [`SHIFT_WIDTH-1:0] linePat [`SPRITE_COUNT];
	logic [`SPRITE_COUNT-1:0] running;
	spritePkg::pixelOutT expQ [$];
	spritePkg::pixelOutT expPix;
	logic stallSeen;
	logic [31:0] rnd;

	int pixErrs = 0;
	int resetErrs = 0;
	int procErrs = 0;
	int testsPassed = 0;
	int testErrBase;

	spriteUnit uut (.*);

	initial begin
		clk33 = 1'b0;
		forever #2 clk33 = ~clk33;
	end

	// Pixel clock enable is high for one clock in four
	always @(negedge clk33) begin
		pixDiv <= pixDiv + 2'd1;
		pixelEn <= (pixDiv == 2'd3);
	end

	// ========================================
	// Checkers
	// ========================================
	// The output pixel only moves on pixelEn edges, so every clock can compare it
	assert property (@(posedge clk33) disable iff (rst)
		pixelOut.valid == expPix.valid && (!expPix.valid ||
			(pixelOut.sprite == expPix.sprite && pixelOut.color == expPix.color)))
		else begin
			pixErrs++;
			$display("** Error pixelOut: got valid=%h sprite=%h color=%h",
				pixelOut.valid, pixelOut.sprite, pixelOut.color);
			$display("** Error pixelOut: expected valid=%h sprite=%h color=%h",
				expPix.valid, expPix.sprite, expPix.color);
		end

	// On the first clock out of reset the bus is open and no pixel shows
	assert property (@(posedge clk33) $fell(rst) |-> busReady && !pixelOut.valid)
		else begin
			resetErrs++;
			$display("** Error after reset: busReady=%h pixelOut.valid=%h",
				busReady, pixelOut.valid);
		end

	// ========================================
	// Reference rules
	// ========================================
	// Code of pixel p of a line with the MSB first
	// Multicolor uses bit pairs and xExpand doubles every pixel
	function automatic logic [1:0] codeAt(input logic [`SHIFT_WIDTH-1:0] pat,
		input logic mc, input logic xExp, input int p);
		int q;
		q = xExp ? p / 2 : p;
		if (mc) begin
			return pat[`SHIFT_WIDTH - 1 - 2 * (q / 2) -: 2];
		end
		return {pat[`SHIFT_WIDTH - 1 - q], 1'b0};
	endfunction

	// Lowest numbered opaque sprite decides the colour
	function automatic spritePkg::pixelOutT pixelAt(input int p);
		spritePkg::pixelOutT px;
		logic [1:0] code;
		int len;
		px = '0;
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			len = spriteCtrl[i].xExpand ? 2 * `SHIFT_WIDTH : `SHIFT_WIDTH;
			if (running[i] && !px.valid && p < len) begin
				code = codeAt(linePat[i], spriteCtrl[i].multicolor,
					spriteCtrl[i].xExpand, p);
				if (code != 2'b00) begin
					px.valid = 1'b1;
					px.sprite = `SPRITE_BITS'(i);
					px.color = (code == 2'b01) ? mcColor0 :
						(code == 2'b11) ? mcColor1 : spriteCtrl[i].color;
				end
			end
		end
		return px;
	endfunction

	// ========================================
	// Stimulus
	// ========================================
	task automatic waitPixel();
		int n;
		n = 0;
		@(posedge clk33);
		while (!pixelEn && n < PixelTimeout) begin
			@(posedge clk33);
			n++;
		end
		if (!pixelEn) begin
			procErrs++;
			$display("Timeout: no pixel enable arrived");
		end
	endtask

	task automatic setSprite(input int idx, input logic act, input logic mc,
		input logic xExp, input logic [8:0] xPos, input logic [`COLOR_BITS-1:0] col);
		@(negedge clk33);
		spriteCtrl[idx] = {act, mc, xExp, xPos, col};
	endtask

	task automatic sendByte(input logic [`SPRITE_BITS-1:0] spr, input logic [7:0] data);
		int n;
		n = 0;
		@(negedge clk33);
		busValid = 1'b1;
		busIn.sprite = spr;
		busIn.data = data;
		// BusReady only changes on the rising edge, so it is safe to look at here
		if (!busReady) begin
			stallSeen = 1'b1;
		end
		while (!busReady && n < ReadyTimeout) begin
			@(negedge clk33);
			n++;
		end
		if (!busReady) begin
			procErrs++;
			$display("Timeout: busReady stayed low for sprite %0d", spr);
		end
		@(posedge clk33);
	endtask

	task automatic sendLine(input logic [`SPRITE_BITS-1:0] spr,
		input logic [`SHIFT_WIDTH-1:0] pat);
		sendByte(spr, pat[23:16]);
		sendByte(spr, pat[15:8]);
		sendByte(spr, pat[7:0]);
		@(negedge clk33);
		busValid = 1'b0;
	endtask

	// Match X and follow the line pixel by pixel with one clear pixel after it
	task automatic showLine(input logic [8:0] xPos);
		int len;
		len = `SHIFT_WIDTH;
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			if (running[i] && spriteCtrl[i].xExpand) begin
				len = 2 * `SHIFT_WIDTH;
			end
		end
		for (int p = 0; p <= len; p++) begin
			expQ.push_back(pixelAt(p));
		end
		waitPixel();
		@(negedge clk33);
		rasterX = xPos;
		waitPixel();
		@(negedge clk33);
		rasterX = 9'd0;
		// The first code is registered one edge after the start and its colour one edge later
		waitPixel();
		while (expQ.size() > 0) begin
			waitPixel();
			@(negedge clk33);
			expPix = expQ.pop_front();
		end
	endtask

	task automatic finishTest(input string name);
		int errs;
		waitPixel();
		errs = pixErrs + resetErrs + procErrs - testErrBase;
		if (errs == 0) begin
			testsPassed++;
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, errs);
		end
		testErrBase = pixErrs + resetErrs + procErrs;
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		void'($urandom(32'h1f2c));
		rst = 1'b1;
		rasterX = 9'd0;
		busIn = '0;
		busValid = 1'b0;
		spriteCtrl = '0;
		mcColor0 = 4'h5;
		mcColor1 = 4'hA;
		running = '0;
		expPix = '0;
		stallSeen = 1'b0;
		testErrBase = 0;
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			linePat[i] = '0;
		end
		repeat (10) @(posedge clk33);
		@(negedge clk33);
		rst = 1'b0;

		// Sprite 1 stays switched off, so its bytes must never show
		setSprite(1, 1'b0, 1'b0, 1'b0, 9'h030, 4'h3);
		rnd = $urandom();
		sendLine(1, rnd[23:0]);
		showLine(9'h030);
		finishTest("reset and inactive sprite");

		setSprite(0, 1'b1, 1'b0, 1'b0, 9'h050, 4'h7);
		rnd = $urandom();
		linePat[0] = rnd[23:0];
		sendLine(0, linePat[0]);
		running = 8'b0000_0001;
		showLine(9'h050);
		finishTest("high resolution");

		// Top byte walks through all four codes
		setSprite(3, 1'b1, 1'b1, 1'b0, 9'h064, 4'hC);
		rnd = $urandom();
		linePat[3] = {8'h1B, rnd[15:0]};
		sendLine(3, linePat[3]);
		running = 8'b0000_1000;
		showLine(9'h064);
		finishTest("multicolor");

		setSprite(4, 1'b1, 1'b0, 1'b1, 9'h080, 4'hE);
		rnd = $urandom();
		linePat[4] = rnd[23:0];
		sendLine(4, linePat[4]);
		running = 8'b0001_0000;
		showLine(9'h080);
		finishTest("x expansion");

		setSprite(2, 1'b1, 1'b0, 1'b0, 9'h090, 4'h2);
		setSprite(5, 1'b1, 1'b0, 1'b0, 9'h090, 4'hD);
		rnd = $urandom();
		linePat[2] = rnd[23:0];
		rnd = $urandom();
		linePat[5] = rnd[23:0];
		sendLine(2, linePat[2]);
		sendLine(5, linePat[5]);
		running = 8'b0010_0100;
		showLine(9'h090);
		finishTest("priority");

		// Second line arrives while the first is still shifting out
		setSprite(6, 1'b1, 1'b0, 1'b0, 9'h120, 4'h9);
		rnd = $urandom();
		linePat[6] = rnd[23:0];
		sendLine(6, linePat[6]);
		rnd = $urandom();
		stallSeen = 1'b0;
		running = 8'b0100_0000;
		fork
			showLine(9'h120);
			begin
				waitPixel();
				waitPixel();
				waitPixel();
				sendLine(6, rnd[23:0]);
			end
		join
		assert (stallSeen) else begin
			procErrs++;
			$display("busReady never dropped while sprite 6 was running");
		end
		linePat[6] = rnd[23:0];
		showLine(9'h120);
		finishTest("back-pressure");

		$display("Tests run 6, passed %0d, failed %0d, errors %0d", testsPassed,
			6 - testsPassed, pixErrs + resetErrs + procErrs);
		if (pixErrs + resetErrs + procErrs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/vicBusPkg.sv
rtl/spritePkg.sv
rtl/spriteFetch.sv
rtl/spritePixelShifter.sv
rtl/spritePriorityMux.sv
rtl/spriteUnit.sv
sim/spriteUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the sprite unit testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module spriteUnitTb -o spriteUnitSim &&
./obj_dir/spriteUnitSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && echo "run.sh: passed" && exit 0 ||
{ echo "run.sh: failed"; exit 1; }
